// ==== src/id_pkg.sv ====
package id_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // opcode field masks per instruction format
  localparam logic [31:0] mask_3r    = 32'hffff_8000;
  localparam logic [31:0] mask_2ri12 = 32'hffc0_0000;
  localparam logic [31:0] mask_1ri20 = 32'hfe00_0000;
  localparam logic [31:0] mask_op6   = 32'hfc00_0000;

  // opcode bits in place, compared after masking
  localparam logic [31:0] op_add_w   = 32'h0010_0000;
  localparam logic [31:0] op_sub_w   = 32'h0011_0000;
  localparam logic [31:0] op_slt     = 32'h0012_0000;
  localparam logic [31:0] op_sltu    = 32'h0012_8000;
  localparam logic [31:0] op_nor     = 32'h0014_0000;
  localparam logic [31:0] op_and     = 32'h0014_8000;
  localparam logic [31:0] op_or      = 32'h0015_0000;
  localparam logic [31:0] op_xor     = 32'h0015_8000;
  localparam logic [31:0] op_slli_w  = 32'h0040_8000;
  localparam logic [31:0] op_srli_w  = 32'h0044_8000;
  localparam logic [31:0] op_srai_w  = 32'h0048_8000;
  localparam logic [31:0] op_addi_w  = 32'h0280_0000;
  localparam logic [31:0] op_lu12i_w = 32'h1400_0000;
  localparam logic [31:0] op_ld_w    = 32'h2880_0000;
  localparam logic [31:0] op_st_w    = 32'h2980_0000;
  localparam logic [31:0] op_jirl    = 32'h4c00_0000;
  localparam logic [31:0] op_b       = 32'h5000_0000;
  localparam logic [31:0] op_bl      = 32'h5400_0000;
  localparam logic [31:0] op_beq     = 32'h5800_0000;
  localparam logic [31:0] op_bne     = 32'h5c00_0000;
  localparam logic [31:0] op_blt     = 32'h6000_0000;
  localparam logic [31:0] op_bge     = 32'h6400_0000;
  localparam logic [31:0] op_bltu    = 32'h6800_0000;
  localparam logic [31:0] op_bgeu    = 32'h6c00_0000;

  // one-hot, add sits in bit 0
  typedef struct packed {
    logic lui;
    logic sra;
    logic srl;
    logic sll;
    logic xor_op;
    logic or_op;
    logic nor_op;
    logic and_op;
    logic sltu;
    logic slt;
    logic sub;
    logic add;
  } alu_op_t;

  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_b,
    br_bl,
    br_jirl
  } br_kind_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fs_to_ds_t;

  typedef struct packed {
    alu_op_t               alu_op;
    logic                  load_op;
    logic                  store_op;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  src2_is_4;
    logic                  gr_we;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic                  need_rj;
    logic                  need_rkd;
    br_kind_t              br_kind;
    logic [xlen-1:0]       br_offs;
  } dec_t;

  typedef struct packed {
    alu_op_t               alu_op;
    logic                  load_op;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  src2_is_4;
    logic                  gr_we;
    logic                  store_op;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rkd_value;
    logic [xlen-1:0]       pc;
  } ds_to_es_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } wb_bus_t;

  typedef struct packed {
    logic                  need_stall;
    logic                  enable;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       data;
  } fwd_bus_t;

endpackage

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  logic [id_pkg::xlen-1:0] inst,
  output id_pkg::dec_t            dec
);

  logic [4:0]  rd;
  logic [4:0]  rj;
  logic [4:0]  rk;
  logic [11:0] i12;
  logic [19:0] i20;
  logic [15:0] i16;
  logic [25:0] i26;

  logic is_add_w, is_sub_w, is_slt, is_sltu, is_nor, is_and, is_or, is_xor;
  logic is_slli_w, is_srli_w, is_srai_w, is_addi_w, is_lu12i_w;
  logic is_ld_w, is_st_w, is_jirl, is_b, is_bl;
  logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
  logic is_reg_alu, is_shift_imm, is_cond_br;

  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i20 = inst[24:5];
  assign i16 = inst[25:10];
  assign i26 = {inst[9:0], inst[25:10]};

  // 3R format
  assign is_add_w = (inst & id_pkg::mask_3r) == id_pkg::op_add_w;
  assign is_sub_w = (inst & id_pkg::mask_3r) == id_pkg::op_sub_w;
  assign is_slt   = (inst & id_pkg::mask_3r) == id_pkg::op_slt;
  assign is_sltu  = (inst & id_pkg::mask_3r) == id_pkg::op_sltu;
  assign is_nor   = (inst & id_pkg::mask_3r) == id_pkg::op_nor;
  assign is_and   = (inst & id_pkg::mask_3r) == id_pkg::op_and;
  assign is_or    = (inst & id_pkg::mask_3r) == id_pkg::op_or;
  assign is_xor   = (inst & id_pkg::mask_3r) == id_pkg::op_xor;

  // shifts share the 3R opcode span, ui5 sits in rk
  assign is_slli_w = (inst & id_pkg::mask_3r) == id_pkg::op_slli_w;
  assign is_srli_w = (inst & id_pkg::mask_3r) == id_pkg::op_srli_w;
  assign is_srai_w = (inst & id_pkg::mask_3r) == id_pkg::op_srai_w;

  assign is_addi_w  = (inst & id_pkg::mask_2ri12) == id_pkg::op_addi_w;
  assign is_ld_w    = (inst & id_pkg::mask_2ri12) == id_pkg::op_ld_w;
  assign is_st_w    = (inst & id_pkg::mask_2ri12) == id_pkg::op_st_w;
  assign is_lu12i_w = (inst & id_pkg::mask_1ri20) == id_pkg::op_lu12i_w;

  assign is_jirl = (inst & id_pkg::mask_op6) == id_pkg::op_jirl;
  assign is_b    = (inst & id_pkg::mask_op6) == id_pkg::op_b;
  assign is_bl   = (inst & id_pkg::mask_op6) == id_pkg::op_bl;
  assign is_beq  = (inst & id_pkg::mask_op6) == id_pkg::op_beq;
  assign is_bne  = (inst & id_pkg::mask_op6) == id_pkg::op_bne;
  assign is_blt  = (inst & id_pkg::mask_op6) == id_pkg::op_blt;
  assign is_bge  = (inst & id_pkg::mask_op6) == id_pkg::op_bge;
  assign is_bltu = (inst & id_pkg::mask_op6) == id_pkg::op_bltu;
  assign is_bgeu = (inst & id_pkg::mask_op6) == id_pkg::op_bgeu;

  assign is_reg_alu = is_add_w | is_sub_w | is_slt | is_sltu |
                      is_nor | is_and | is_or | is_xor;
  assign is_shift_imm = is_slli_w | is_srli_w | is_srai_w;
  assign is_cond_br = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

  always_comb begin
    dec = '0;

    // ld/st and link address all go through the adder
    dec.alu_op.add    = is_add_w | is_addi_w | is_ld_w | is_st_w | is_jirl | is_bl;
    dec.alu_op.sub    = is_sub_w;
    dec.alu_op.slt    = is_slt;
    dec.alu_op.sltu   = is_sltu;
    dec.alu_op.and_op = is_and;
    dec.alu_op.nor_op = is_nor;
    dec.alu_op.or_op  = is_or;
    dec.alu_op.xor_op = is_xor;
    dec.alu_op.sll    = is_slli_w;
    dec.alu_op.srl    = is_srli_w;
    dec.alu_op.sra    = is_srai_w;
    dec.alu_op.lui    = is_lu12i_w;

    dec.load_op     = is_ld_w;
    dec.store_op    = is_st_w;
    dec.src1_is_pc  = is_jirl | is_bl;
    dec.src2_is_imm = is_shift_imm | is_addi_w | is_lu12i_w | is_ld_w | is_st_w;
    dec.src2_is_4   = is_jirl | is_bl;
    dec.gr_we       = is_reg_alu | is_shift_imm | is_addi_w | is_lu12i_w |
                      is_ld_w | is_jirl | is_bl;
    dec.dest        = is_bl ? 5'd1 : rd;

    if (dec.src2_is_4) begin
      dec.imm = 32'd4;
    end else if (is_lu12i_w) begin
      dec.imm = {i20, 12'b0};
    end else begin
      // also covers ui5 of the shifts
      dec.imm = {{20{i12[11]}}, i12};
    end

    dec.raddr1   = rj;
    dec.raddr2   = (is_st_w | is_cond_br) ? rd : rk;
    dec.need_rj  = is_reg_alu | is_shift_imm | is_addi_w | is_ld_w | is_st_w |
                   is_cond_br | is_jirl;
    dec.need_rkd = is_reg_alu | is_cond_br | is_st_w;

    if (is_beq)       dec.br_kind = id_pkg::br_beq;
    else if (is_bne)  dec.br_kind = id_pkg::br_bne;
    else if (is_blt)  dec.br_kind = id_pkg::br_blt;
    else if (is_bge)  dec.br_kind = id_pkg::br_bge;
    else if (is_bltu) dec.br_kind = id_pkg::br_bltu;
    else if (is_bgeu) dec.br_kind = id_pkg::br_bgeu;
    else if (is_b)    dec.br_kind = id_pkg::br_b;
    else if (is_bl)   dec.br_kind = id_pkg::br_bl;
    else if (is_jirl) dec.br_kind = id_pkg::br_jirl;
    else              dec.br_kind = id_pkg::br_none;

    dec.br_offs = (is_b | is_bl) ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
  end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile (
  input  logic                          clk,
  input  logic [id_pkg::reg_addr_w-1:0] raddr1,
  input  logic [id_pkg::reg_addr_w-1:0] raddr2,
  output logic [id_pkg::xlen-1:0]       rdata1,
  output logic [id_pkg::xlen-1:0]       rdata2,
  input  id_pkg::wb_bus_t               wb
);

  logic [id_pkg::xlen-1:0] regs [32];

  // r0 is never written
  always_ff @(posedge clk) begin
    if (wb.we && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
  input  logic [id_pkg::reg_addr_w-1:0] raddr,
  input  logic                          need,
  input  logic [id_pkg::xlen-1:0]       rf_rdata,
  input  id_pkg::fwd_bus_t              es_fwd,
  input  id_pkg::fwd_bus_t              ms_fwd,
  input  id_pkg::wb_bus_t               wb,
  output logic [id_pkg::xlen-1:0]       value,
  output logic                          stall
);

  logic lookup;
  logic es_hit;
  logic ms_hit;
  logic wb_hit;

  // r0 is hardwired, nothing to forward
  assign lookup = need && (raddr != '0);

  assign es_hit = lookup && es_fwd.enable && (es_fwd.dest == raddr);
  assign ms_hit = lookup && ms_fwd.enable && (ms_fwd.dest == raddr);
  assign wb_hit = lookup && wb.we && (wb.waddr == raddr);

  // youngest producer wins
  always_comb begin
    if (es_hit) begin
      value = es_fwd.data;
      stall = es_fwd.need_stall;
    end else if (ms_hit) begin
      value = ms_fwd.data;
      stall = ms_fwd.need_stall;
    end else if (wb_hit) begin
      value = wb.wdata;
      stall = 1'b0;
    end else begin
      value = rf_rdata;
      stall = 1'b0;
    end
  end

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
  input  logic                    valid,
  input  id_pkg::br_kind_t        kind,
  input  logic [id_pkg::xlen-1:0] pc,
  input  logic [id_pkg::xlen-1:0] rj_value,
  input  logic [id_pkg::xlen-1:0] rkd_value,
  input  logic [id_pkg::xlen-1:0] offs,
  output id_pkg::br_bus_t         br
);

  logic eq;
  logic lt_s;
  logic lt_u;
  logic cond;

  assign eq   = rj_value == rkd_value;
  assign lt_s = $signed(rj_value) < $signed(rkd_value);
  assign lt_u = rj_value < rkd_value;

  always_comb begin
    case (kind)
      id_pkg::br_beq:  cond = eq;
      id_pkg::br_bne:  cond = !eq;
      id_pkg::br_blt:  cond = lt_s;
      id_pkg::br_bge:  cond = !lt_s;
      id_pkg::br_bltu: cond = lt_u;
      id_pkg::br_bgeu: cond = !lt_u;
      // unconditional jumps
      id_pkg::br_b,
      id_pkg::br_bl,
      id_pkg::br_jirl: cond = 1'b1;
      default:         cond = 1'b0;
    endcase
  end

  assign br.taken  = valid && cond;
  assign br.target = (kind == id_pkg::br_jirl) ? rj_value + offs : pc + offs;

endmodule

// ==== src/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              es_allowin,
  output logic              ds_allowin,
  input  logic              fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t fs_to_ds_bus,
  output logic              ds_to_es_valid,
  output id_pkg::ds_to_es_t ds_to_es_bus,
  output id_pkg::br_bus_t   br_bus,
  input  id_pkg::wb_bus_t   ws_to_rf_bus,
  input  id_pkg::fwd_bus_t  es_fwd,
  input  id_pkg::fwd_bus_t  ms_fwd
);

  logic                    ds_valid;
  id_pkg::fs_to_ds_t       fs_r;
  id_pkg::dec_t            dec;
  logic [id_pkg::xlen-1:0] rf_rdata1;
  logic [id_pkg::xlen-1:0] rf_rdata2;
  logic [id_pkg::xlen-1:0] rj_value;
  logic [id_pkg::xlen-1:0] rkd_value;
  logic                    rj_stall;
  logic                    rkd_stall;
  logic                    ds_ready_go;

  assign ds_ready_go    = !(rj_stall || rkd_stall);
  assign ds_allowin     = !ds_valid || (es_allowin && ds_ready_go);
  assign ds_to_es_valid = ds_valid && ds_ready_go;

  // a taken branch flushes whatever fetch offers on the same edge
  always_ff @(posedge clk) begin
    if (rst || br_bus.taken) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs_to_ds_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs_to_ds_valid && ds_allowin && !br_bus.taken) begin
      fs_r <= fs_to_ds_bus;
    end
  end

  inst_decoder inst_decoder_inst (
    .inst (fs_r.inst),
    .dec  (dec)
  );

  regfile regfile_inst (
    .clk    (clk),
    .raddr1 (dec.raddr1),
    .raddr2 (dec.raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wb     (ws_to_rf_bus)
  );

  operand_forward rj_forward_inst (
    .raddr    (dec.raddr1),
    .need     (dec.need_rj),
    .rf_rdata (rf_rdata1),
    .es_fwd   (es_fwd),
    .ms_fwd   (ms_fwd),
    .wb       (ws_to_rf_bus),
    .value    (rj_value),
    .stall    (rj_stall)
  );

  operand_forward rkd_forward_inst (
    .raddr    (dec.raddr2),
    .need     (dec.need_rkd),
    .rf_rdata (rf_rdata2),
    .es_fwd   (es_fwd),
    .ms_fwd   (ms_fwd),
    .wb       (ws_to_rf_bus),
    .value    (rkd_value),
    .stall    (rkd_stall)
  );

  // resolve only once both operands are real
  branch_unit branch_unit_inst (
    .valid     (ds_valid && ds_ready_go),
    .kind      (dec.br_kind),
    .pc        (fs_r.pc),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .offs      (dec.br_offs),
    .br        (br_bus)
  );

  assign ds_to_es_bus = '{
    alu_op:      dec.alu_op,
    load_op:     dec.load_op,
    src1_is_pc:  dec.src1_is_pc,
    src2_is_imm: dec.src2_is_imm,
    src2_is_4:   dec.src2_is_4,
    gr_we:       dec.gr_we,
    store_op:    dec.store_op,
    dest:        dec.dest,
    imm:         dec.imm,
    rj_value:    rj_value,
    rkd_value:   rkd_value,
    pc:          fs_r.pc
  };

endmodule

// ==== testbench/id_tests.svh ====
task automatic reset_state_test();
  begin_test();
  @(negedge clk);
  check_bit("reset_state allowin", 1'b1, ds_allowin);
  check_bit("reset_state valid", 1'b0, ds_to_es_valid);
  check_bit("reset_state taken", 1'b0, br_bus.taken);
  drive_edge();
  report_test("reset_state");
endtask

task automatic alu_reg_test();
  logic [31:0]       ops [11];
  logic [4:0]        rd;
  logic [4:0]        rj;
  logic [4:0]        rk;
  logic [31:0]       inst;
  logic [31:0]       pc;
  id_pkg::ds_to_es_t exp;
  begin_test();
  ops = '{id_pkg::op_add_w, id_pkg::op_sub_w, id_pkg::op_slt, id_pkg::op_sltu,
          id_pkg::op_and, id_pkg::op_nor, id_pkg::op_or, id_pkg::op_xor,
          id_pkg::op_slli_w, id_pkg::op_srli_w, id_pkg::op_srai_w};
  // last pass repeats add.w on r0
  for (int i = 0; i < 12; i++) begin
    rd = 5'($urandom_range(31, 1));
    rj = (i == 11) ? 5'd0 : 5'($urandom_range(31, 1));
    rk = (i == 11) ? 5'd0 : 5'($urandom_range(31, 1));
    inst = ops[i % 11] | {17'b0, rk, rj, rd};
    pc = 32'h1c00_0000 + 32'(i * 4);
    exp = word_fields(inst, pc);
    exp.alu_op = alu_sel(i % 11);
    exp.gr_we = 1'b1;
    exp.src2_is_imm = ((i % 11) >= 8);
    issue_and_check("alu_reg", inst, pc, exp);
  end
  report_test("alu_reg");
endtask

task automatic imm_form_test();
  logic [31:0]       inst;
  id_pkg::ds_to_es_t exp;
  begin_test();
  inst = id_pkg::op_addi_w | {10'b0, 12'hda5, 5'd13, 5'd12};
  exp = word_fields(inst, 32'h1c00_0100);
  exp.alu_op = alu_sel(0);
  exp.src2_is_imm = 1'b1;
  exp.gr_we = 1'b1;
  issue_and_check("imm_addi", inst, 32'h1c00_0100, exp);
  inst = id_pkg::op_lu12i_w | {7'b0, 20'hfedcb, 5'd14};
  exp = word_fields(inst, 32'h1c00_0104);
  exp.imm = {20'hfedcb, 12'b0};
  exp.alu_op = alu_sel(11);
  exp.src2_is_imm = 1'b1;
  exp.gr_we = 1'b1;
  issue_and_check("imm_lu12i", inst, 32'h1c00_0104, exp);
  inst = id_pkg::op_ld_w | {10'b0, 12'h7f0, 5'd15, 5'd16};
  exp = word_fields(inst, 32'h1c00_0108);
  exp.alu_op = alu_sel(0);
  exp.load_op = 1'b1;
  exp.src2_is_imm = 1'b1;
  exp.gr_we = 1'b1;
  issue_and_check("imm_ld", inst, 32'h1c00_0108, exp);
  // store data comes from rd
  inst = id_pkg::op_st_w | {10'b0, 12'h804, 5'd17, 5'd18};
  exp = word_fields(inst, 32'h1c00_010c);
  exp.alu_op = alu_sel(0);
  exp.store_op = 1'b1;
  exp.src2_is_imm = 1'b1;
  exp.rkd_value = model_regs[18];
  issue_and_check("imm_st", inst, 32'h1c00_010c, exp);
  report_test("imm_form");
endtask

task automatic branch_test();
  logic [31:0]     ops [6];
  logic [31:0]     a_vals [3];
  logic [31:0]     b_vals [3];
  logic [31:0]     inst;
  logic [31:0]     follow;
  logic [31:0]     pc;
  logic [31:0]     a;
  logic [31:0]     b;
  logic [15:0]     offs;
  logic            cond;
  id_pkg::br_bus_t exp_br;
  begin_test();
  ops = '{id_pkg::op_beq, id_pkg::op_bne, id_pkg::op_blt,
          id_pkg::op_bge, id_pkg::op_bltu, id_pkg::op_bgeu};
  // equal, then negative against small positive both ways
  a_vals = '{32'h0000_1234, 32'h8000_0000, 32'h0000_0001};
  b_vals = '{32'h0000_1234, 32'h0000_0001, 32'h8000_0000};
  follow = id_pkg::op_add_w | {17'b0, 5'd0, 5'd0, 5'd2};
  for (int p = 0; p < 3; p++) begin
    write_reg(5'd5, a_vals[p]);
    write_reg(5'd6, b_vals[p]);
    a = a_vals[p];
    b = b_vals[p];
    for (int k = 0; k < 6; k++) begin
      offs = 16'($urandom);
      pc = 32'h1c00_1000 + 32'(k * 4);
      inst = ops[k] | {6'b0, offs, 5'd5, 5'd6};
      case (k)
        0: cond = (a == b);
        1: cond = (a != b);
        2: cond = ($signed(a) < $signed(b));
        3: cond = !($signed(a) < $signed(b));
        4: cond = (a < b);
        5: cond = !(a < b);
        default: cond = 1'b0;
      endcase
      exp_br = '{taken: cond, target: pc + offs16(offs)};
      accept_then_offer(inst, pc, follow, pc + 32'd4);
      check_bit("branch valid", 1'b1, ds_to_es_valid);
      check_br("branch", exp_br, br_bus);
      drive_edge();
      fs_to_ds_valid = 1'b0;
      @(negedge clk);
      // only a branch not taken lets the next word in
      check_bit("branch after valid", !cond, ds_to_es_valid);
      check_bit("branch after taken", 1'b0, br_bus.taken);
      drive_edge();
    end
  end
  report_test("branch");
endtask

task automatic jump_test();
  logic [31:0]       insts [3];
  logic [31:0]       pcs [3];
  logic [31:0]       follow;
  id_pkg::ds_to_es_t exps [3];
  id_pkg::br_bus_t   brs [3];
  begin_test();
  pcs = '{32'h1c00_2000, 32'h1c00_2100, 32'h1c00_2200};
  follow = id_pkg::op_add_w | {17'b0, 5'd0, 5'd0, 5'd2};
  insts[0] = id_pkg::op_b | {6'b0, 16'h0123, 10'h000};
  exps[0] = word_fields(insts[0], pcs[0]);
  brs[0] = '{taken: 1'b1, target: pcs[0] + offs26(26'h000_0123)};
  insts[1] = id_pkg::op_bl | {6'b0, 16'hfff0, 10'h3ff};
  exps[1] = word_fields(insts[1], pcs[1]);
  exps[1].alu_op = alu_sel(0);
  exps[1].src1_is_pc = 1'b1;
  exps[1].src2_is_4 = 1'b1;
  exps[1].gr_we = 1'b1;
  exps[1].dest = 5'd1;
  exps[1].imm = 32'd4;
  brs[1] = '{taken: 1'b1, target: pcs[1] + offs26(26'h3ff_fff0)};
  // jirl target is register based
  insts[2] = id_pkg::op_jirl | {6'b0, 16'h0010, 5'd20, 5'd1};
  exps[2] = word_fields(insts[2], pcs[2]);
  exps[2].alu_op = alu_sel(0);
  exps[2].src1_is_pc = 1'b1;
  exps[2].src2_is_4 = 1'b1;
  exps[2].gr_we = 1'b1;
  exps[2].imm = 32'd4;
  brs[2] = '{taken: 1'b1, target: model_regs[20] + offs16(16'h0010)};
  for (int i = 0; i < 3; i++) begin
    accept_then_offer(insts[i], pcs[i], follow, pcs[i] + 32'd4);
    check_es_bus("jump", exps[i], ds_to_es_bus);
    check_br("jump", brs[i], br_bus);
    drive_edge();
    fs_to_ds_valid = 1'b0;
    @(negedge clk);
    check_bit("jump after valid", 1'b0, ds_to_es_valid);
    drive_edge();
  end
  report_test("jump");
endtask

task automatic forward_test();
  logic [31:0]       inst;
  id_pkg::ds_to_es_t exp;
  begin_test();
  inst = id_pkg::op_add_w | {17'b0, 5'd8, 5'd7, 5'd3};
  es_allowin = 1'b0;
  es_fwd = '{need_stall: 1'b0, enable: 1'b1, dest: 5'd7, data: 32'haaaa_0001};
  ms_fwd = '{need_stall: 1'b0, enable: 1'b1, dest: 5'd7, data: 32'hbbbb_0002};
  ws_to_rf_bus = '{we: 1'b1, waddr: 5'd7, wdata: 32'hcccc_0003};
  model_regs[7] = 32'hcccc_0003;
  exp = word_fields(inst, 32'h1c00_3000);
  exp.alu_op = alu_sel(0);
  exp.gr_we = 1'b1;
  present(inst, 32'h1c00_3000);
  exp.rj_value = 32'haaaa_0001;
  check_es_bus("forward execute", exp, ds_to_es_bus);
  drive_edge();
  es_fwd.enable = 1'b0;
  @(negedge clk);
  exp.rj_value = 32'hbbbb_0002;
  check_es_bus("forward memory", exp, ds_to_es_bus);
  drive_edge();
  ms_fwd.enable = 1'b0;
  // register file still holds the older write
  ws_to_rf_bus.wdata = 32'hdddd_0004;
  model_regs[7] = 32'hdddd_0004;
  @(negedge clk);
  exp.rj_value = 32'hdddd_0004;
  check_es_bus("forward write-back", exp, ds_to_es_bus);
  drive_edge();
  ws_to_rf_bus.we = 1'b0;
  @(negedge clk);
  check_es_bus("forward regfile", exp, ds_to_es_bus);
  drive_edge();
  es_allowin = 1'b1;
  @(negedge clk);
  check_bit("forward release valid", 1'b1, ds_to_es_valid);
  drive_edge();
  report_test("forward");
endtask

task automatic stall_test();
  logic [31:0]       inst;
  id_pkg::ds_to_es_t exp;
  begin_test();
  inst = id_pkg::op_add_w | {17'b0, 5'd10, 5'd9, 5'd4};
  es_fwd = '{need_stall: 1'b1, enable: 1'b1, dest: 5'd9, data: 32'h5a5a_0009};
  exp = word_fields(inst, 32'h1c00_4000);
  exp.alu_op = alu_sel(0);
  exp.gr_we = 1'b1;
  exp.rj_value = 32'h5a5a_0009;
  present(inst, 32'h1c00_4000);
  for (int i = 0; i < 4; i++) begin
    check_bit("stall valid", 1'b0, ds_to_es_valid);
    check_bit("stall allowin", 1'b0, ds_allowin);
    check_es_bus("stall held", exp, ds_to_es_bus);
    drive_edge();
    @(negedge clk);
  end
  drive_edge();
  es_fwd.need_stall = 1'b0;
  @(negedge clk);
  check_bit("stall release valid", 1'b1, ds_to_es_valid);
  check_bit("stall release allowin", 1'b1, ds_allowin);
  check_es_bus("stall release", exp, ds_to_es_bus);
  drive_edge();
  es_fwd.enable = 1'b0;
  @(negedge clk);
  check_bit("stall drained", 1'b0, ds_to_es_valid);
  drive_edge();
  report_test("stall");
endtask

task automatic backpressure_test();
  logic [31:0]       inst1;
  logic [31:0]       inst2;
  id_pkg::ds_to_es_t exp1;
  id_pkg::ds_to_es_t exp2;
  begin_test();
  inst1 = id_pkg::op_addi_w | {10'b0, 12'h011, 5'd21, 5'd22};
  inst2 = id_pkg::op_ld_w | {10'b0, 12'h020, 5'd23, 5'd24};
  exp1 = word_fields(inst1, 32'h1c00_5000);
  exp1.alu_op = alu_sel(0);
  exp1.src2_is_imm = 1'b1;
  exp1.gr_we = 1'b1;
  exp2 = word_fields(inst2, 32'h1c00_5004);
  exp2.alu_op = alu_sel(0);
  exp2.load_op = 1'b1;
  exp2.src2_is_imm = 1'b1;
  exp2.gr_we = 1'b1;
  es_allowin = 1'b0;
  present(inst1, 32'h1c00_5000);
  drive_edge();
  // second fetch waits behind the held one
  fs_to_ds_valid = 1'b1;
  fs_to_ds_bus = '{pc: 32'h1c00_5004, inst: inst2};
  for (int i = 0; i < 3; i++) begin
    @(negedge clk);
    check_bit("backpressure valid", 1'b1, ds_to_es_valid);
    check_bit("backpressure allowin", 1'b0, ds_allowin);
    check_es_bus("backpressure held", exp1, ds_to_es_bus);
    drive_edge();
  end
  es_allowin = 1'b1;
  @(negedge clk);
  check_bit("backpressure release allowin", 1'b1, ds_allowin);
  check_es_bus("backpressure release", exp1, ds_to_es_bus);
  drive_edge();
  fs_to_ds_valid = 1'b0;
  @(negedge clk);
  check_bit("backpressure second valid", 1'b1, ds_to_es_valid);
  check_es_bus("backpressure second", exp2, ds_to_es_bus);
  drive_edge();
  report_test("backpressure");
endtask

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

  logic              clk;
  logic              rst;
  logic              es_allowin;
  logic              ds_allowin;
  logic              fs_to_ds_valid;
  id_pkg::fs_to_ds_t fs_to_ds_bus;
  logic              ds_to_es_valid;
  id_pkg::ds_to_es_t ds_to_es_bus;
  id_pkg::br_bus_t   br_bus;
  id_pkg::wb_bus_t   ws_to_rf_bus;
  id_pkg::fwd_bus_t  es_fwd;
  id_pkg::fwd_bus_t  ms_fwd;

  // register values written so far through write-back
  logic [31:0] model_regs [32];

  int cycles;
  int checks;
  int errors;
  int test_errors;

  // tests take roughly 200 cycles
  localparam int cycle_limit = 3000;

  id_stage id_stage_inst (
    .clk            (clk),
    .rst            (rst),
    .es_allowin     (es_allowin),
    .ds_allowin     (ds_allowin),
    .fs_to_ds_valid (fs_to_ds_valid),
    .fs_to_ds_bus   (fs_to_ds_bus),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .br_bus         (br_bus),
    .ws_to_rf_bus   (ws_to_rf_bus),
    .es_fwd         (es_fwd),
    .ms_fwd         (ms_fwd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, tests still running after %0d cycles", cycles);
    $display("TEST FAIL");
    $finish;
  end

  task automatic drive_edge();
    @(posedge clk);
    #2;
  endtask

  task automatic check_es_bus(input string name, input id_pkg::ds_to_es_t expected,
                              input id_pkg::ds_to_es_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_br(input string name, input id_pkg::br_bus_t expected,
                          input id_pkg::br_bus_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - test_errors);
    end
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    ws_to_rf_bus = '{we: 1'b1, waddr: addr, wdata: data};
    drive_edge();
    ws_to_rf_bus.we = 1'b0;
    if (addr != 5'd0) begin
      model_regs[addr] = data;
    end
  endtask

  task automatic init_regs();
    for (int i = 1; i < 32; i++) begin
      write_reg(5'(i), $urandom);
    end
  endtask

  // holds the word on the fetch bus until decode takes it
  task automatic offer(input logic [31:0] inst_word, input logic [31:0] pc_value);
    fs_to_ds_valid = 1'b1;
    fs_to_ds_bus = '{pc: pc_value, inst: inst_word};
    @(negedge clk);
    while (!ds_allowin) begin
      @(negedge clk);
    end
    drive_edge();
  endtask

  // offers one word to decode and returns at the sample point after acceptance
  task automatic present(input logic [31:0] inst_word, input logic [31:0] pc_value);
    offer(inst_word, pc_value);
    fs_to_ds_valid = 1'b0;
    @(negedge clk);
  endtask

  // fetch keeps offering the next word while the first one resolves
  task automatic accept_then_offer(input logic [31:0] inst_word, input logic [31:0] pc_value,
                                   input logic [31:0] next_word, input logic [31:0] next_pc);
    offer(inst_word, pc_value);
    fs_to_ds_bus = '{pc: next_pc, inst: next_word};
    @(negedge clk);
  endtask

  task automatic issue_and_check(input string name, input logic [31:0] inst_word,
                                 input logic [31:0] pc_value, input id_pkg::ds_to_es_t exp);
    present(inst_word, pc_value);
    check_bit(name, 1'b1, ds_to_es_valid);
    check_es_bus(name, exp, ds_to_es_bus);
    drive_edge();
  endtask

  function automatic id_pkg::alu_op_t alu_sel(input int idx);
    return id_pkg::alu_op_t'(12'b1 << idx);
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] offs16(input logic [15:0] v);
    return {{14{v[15]}}, v, 2'b00};
  endfunction

  function automatic logic [31:0] offs26(input logic [25:0] v);
    return {{4{v[25]}}, v, 2'b00};
  endfunction

  // fields straight from the instruction word with all controls cleared
  function automatic id_pkg::ds_to_es_t word_fields(input logic [31:0] inst_word,
                                                    input logic [31:0] pc_value);
    id_pkg::ds_to_es_t e;
    e = '0;
    e.dest = inst_word[4:0];
    e.imm = sext12(inst_word[21:10]);
    e.rj_value = model_regs[inst_word[9:5]];
    e.rkd_value = model_regs[inst_word[14:10]];
    e.pc = pc_value;
    return e;
  endfunction

  `include "id_tests.svh"

  initial begin
    void'($urandom(32'h0f38_b311));
    rst = 1'b1;
    es_allowin = 1'b1;
    fs_to_ds_valid = 1'b0;
    fs_to_ds_bus = '0;
    ws_to_rf_bus = '0;
    es_fwd = '0;
    ms_fwd = '0;
    checks = 0;
    errors = 0;
    model_regs[0] = 32'd0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_state_test();
    init_regs();
    alu_reg_test();
    imm_form_test();
    branch_test();
    jump_test();
    forward_test();
    stall_test();
    backpressure_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+testbench
src/id_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_stage.sv
testbench/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then scan the log
rm -rf obj_dir sim.log
verilator --binary -f src.f --top-module tb_id_stage -o tb_id_stage \
  && ./obj_dir/tb_id_stage > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log
